/* all.f */
verilog/tlk_pkg.sv
verilog/tlk2711_tx.sv
verilog/tlk2711_rx.sv
verilog/word_fifo.sv
verilog/frame_checker.sv
verilog/tlk2711.sv
bench/tlk_monitor.sv
bench/tb_tlk2711.sv

/* Makefile */
# Verilator flow for the TLK2711 link subsystem

VERILATOR ?= verilator
TOP       ?= tb_tlk2711
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

PASS_MSG := Simulation completed successfully
FAIL_MSG := Simulation failed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "sim FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "sim ended without result"; exit 1; fi
	@echo "sim PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/link_stim.txt */
# name mode frames bad_frame flip_mask(hex)
# mode 0 idle, 1 frame, 2 prbs, 3 loop; mask 0000 sends every frame clean
frame_one      1 1 0 0000
frame_clean    1 4 0 0000
frame_flip     1 4 2 0010
frame_flip_hi  1 3 0 8001
idle_starts    0 3 0 0000
prbs_starts    2 2 0 0000
loop_starts    3 2 0 0000
frame_long     1 6 5 ffff
frame_after    1 2 0 0000

/* bench/tb_tlk2711.sv */
`timescale 1ns/1ns

module tb_tlk2711
    import tlk_pkg::*;
();

    logic             clk_80 = 1'b0;
    logic             reset_i;
    logic             start;
    logic [1:0]       mode;
    logic [15:0]      txd;
    logic             tkmsb;
    logic             tklsb;
    logic             loopen;
    logic             prbsen;
    logic             enable;
    logic             lckrefn;
    logic             testen;
    logic             tx_busy;
    logic [15:0]      rxd;
    logic             rkmsb;
    logic             rklsb;
    logic [CNT_W-1:0] frames_ok;
    logic [CNT_W-1:0] frames_bad;

    // monitor handshake
    logic             begin_req;
    logic             pins_req;
    logic             end_req;
    logic [127:0]     name;
    logic [CNT_W-1:0] exp_ok;
    logic [CNT_W-1:0] exp_bad;
    int               tests_done;
    int               check_errors;

    // loopback corruption
    logic             corrupt;
    logic [15:0]      flip_mask;
    logic [4:0]       data_idx = 5'd0;

    // stimulus table
    logic [127:0]     names[$];
    int               modes[$];
    int               frame_cnt[$];
    int               bad_idx[$];
    logic [15:0]      masks[$];

    integer           seed;
    int               cycles = 0;
    int               cycle_limit = 200;
    int               bad_lines = 0;

    always #20 clk_80 = ~clk_80;

    tlk2711 DUT (
        .clk_80       (clk_80),
        .reset_i      (reset_i),
        .start_i      (start),
        .mode_i       (mode),
        .txd_o        (txd),
        .tkmsb_o      (tkmsb),
        .tklsb_o      (tklsb),
        .loopen_o     (loopen),
        .prbsen_o     (prbsen),
        .enable_o     (enable),
        .lckrefn_o    (lckrefn),
        .testen_o     (testen),
        .tx_busy_o    (tx_busy),
        .rxd_i        (rxd),
        .rkmsb_i      (rkmsb),
        .rklsb_i      (rklsb),
        .frames_ok_o  (frames_ok),
        .frames_bad_o (frames_bad)
    );

    tlk_monitor mon (
        .clk_80       (clk_80),
        .frames_ok_i  (frames_ok),
        .frames_bad_i (frames_bad),
        .loopen_i     (loopen),
        .prbsen_i     (prbsen),
        .enable_i     (enable),
        .lckrefn_i    (lckrefn),
        .testen_i     (testen),
        .begin_i      (begin_req),
        .pins_i       (pins_req),
        .end_i        (end_req),
        .name_i       (name),
        .mode_i       (mode),
        .exp_ok_i     (exp_ok),
        .exp_bad_i    (exp_bad),
        .tests_o      (tests_done),
        .errors_o     (check_errors)
    );

    // index of the data word now on txd
    always @(posedge clk_80) begin
        if (tkmsb && tklsb && txd == K_SOF) begin
            data_idx <= 5'd0;
        end else if (!tkmsb && !tklsb && data_idx != 5'h1f) begin
            data_idx <= data_idx + 5'd1;
        end
    end

    assign rxd   = txd ^ ((corrupt && !tkmsb && !tklsb && data_idx == 5'd4) ? flip_mask : 16'h0);
    assign rkmsb = tkmsb;
    assign rklsb = tklsb;

    always @(posedge clk_80) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic pulse_start;
        @(posedge clk_80);
        #2 start = 1'b1;
        @(posedge clk_80);
        #2 start = 1'b0;
    endtask

    task automatic run_test(input int i);
        int f;
        int gap;
        int accepted;
        @(posedge clk_80);
        #2;
        accepted  = (modes[i] == int'(MODE_FRAME)) ? frame_cnt[i] : 0;
        exp_bad   = (accepted > 0 && masks[i] != 16'h0 && bad_idx[i] < accepted) ? 1 : 0;
        exp_ok    = CNT_W'(accepted) - exp_bad;
        mode      = modes[i][1:0];
        name      = names[i];
        flip_mask = masks[i];
        begin_req = 1'b1;
        @(posedge clk_80);
        #2 begin_req = 1'b0;
        pins_req = 1'b1;
        @(posedge clk_80);
        #2 pins_req = 1'b0;
        for (f = 0; f < frame_cnt[i]; f++) begin
            corrupt = (f == bad_idx[i]);
            pulse_start();
            // a second start while busy must be ignored
            if (tx_busy) begin
                pulse_start();
            end
            while (tx_busy) begin
                @(posedge clk_80);
                #2;
            end
            corrupt = 1'b0;
            gap = $unsigned($random(seed)) % 4;
            repeat (gap) @(posedge clk_80);
        end
        repeat (8) @(posedge clk_80);
        #2 end_req = 1'b1;
        @(posedge clk_80);
        #2 end_req = 1'b0;
    endtask

    initial begin : main
        int          fd;
        int          n;
        int          t_mode;
        int          t_frames;
        int          t_bad;
        logic [127:0] t_name;
        logic [15:0] t_mask;
        string       line;
        seed      = 32'hc810;
        reset_i   = 1'b1;
        start     = 1'b0;
        mode      = MODE_IDLE;
        begin_req = 1'b0;
        pins_req  = 1'b0;
        end_req   = 1'b0;
        name      = '0;
        exp_ok    = '0;
        exp_bad   = '0;
        corrupt   = 1'b0;
        flip_mask = 16'h0;
        fd = $fopen("bench/link_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open bench/link_stim.txt");
            $display("Simulation failed");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %d %d %d %h", t_name, t_mode, t_frames, t_bad, t_mask);
                    if (n == 5) begin
                        names.push_back(t_name);
                        modes.push_back(t_mode);
                        frame_cnt.push_back(t_frames);
                        bad_idx.push_back(t_bad);
                        masks.push_back(t_mask);
                        cycle_limit += t_frames * (FRAME_LEN + IDLE_GAP + 8) + 16;
                    end else begin
                        $display("stim line could not be parsed: %s", line);
                        bad_lines++;
                    end
                end
            end
            $fclose(fd);
            repeat (16) @(posedge clk_80);
            #2 reset_i = 1'b0;
            for (int i = 0; i < names.size(); i++) begin
                run_test(i);
            end
            repeat (2) @(posedge clk_80);
            $display("tests %0d, failed checks %0d, bad stim lines %0d",
                     tests_done, check_errors, bad_lines);
            if (check_errors == 0 && bad_lines == 0 && tests_done == names.size()
                && tests_done > 0) begin
                $display("Simulation completed successfully");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

endmodule

/* bench/tlk_monitor.sv */
`timescale 1ns/1ns

module tlk_monitor
    import tlk_pkg::*;
(
    input  logic             clk_80,
    input  logic [CNT_W-1:0] frames_ok_i,
    input  logic [CNT_W-1:0] frames_bad_i,
    input  logic             loopen_i,
    input  logic             prbsen_i,
    input  logic             enable_i,
    input  logic             lckrefn_i,
    input  logic             testen_i,
    input  logic             begin_i,
    input  logic             pins_i,
    input  logic             end_i,
    input  logic [127:0]     name_i,
    input  logic [1:0]       mode_i,
    input  logic [CNT_W-1:0] exp_ok_i,
    input  logic [CNT_W-1:0] exp_bad_i,
    output int               tests_o,
    output int               errors_o
);

    logic [CNT_W-1:0] base_ok;
    logic [CNT_W-1:0] base_bad;
    int               test_errs = 0;
    int               n_tests = 0;
    int               n_errors = 0;

    assign tests_o  = n_tests;
    assign errors_o = n_errors;

    always @(posedge clk_80) begin : watch
        logic [4:0]       pins_exp;
        logic [4:0]       pins_got;
        logic [CNT_W-1:0] got_ok;
        logic [CNT_W-1:0] got_bad;
        // loopen, prbsen, enable, lckrefn, testen
        pins_exp = {mode_i == MODE_LOOP, mode_i == MODE_PRBS, 1'b1, 1'b1, 1'b0};
        pins_got = {loopen_i, prbsen_i, enable_i, lckrefn_i, testen_i};
        got_ok   = frames_ok_i - base_ok;
        got_bad  = frames_bad_i - base_bad;
        if (begin_i) begin
            base_ok   = frames_ok_i;
            base_bad  = frames_bad_i;
            test_errs = 0;
        end
        if (pins_i && pins_got != pins_exp) begin
            $display("CHECK FAILED %0s pins expected %b actual %b", name_i, pins_exp, pins_got);
            test_errs = test_errs + 1;
        end
        if (end_i) begin
            if (got_ok != exp_ok_i) begin
                $display("CHECK FAILED %0s frames_ok delta expected %0d actual %0d",
                         name_i, exp_ok_i, got_ok);
                test_errs = test_errs + 1;
            end
            if (got_bad != exp_bad_i) begin
                $display("CHECK FAILED %0s frames_bad delta expected %0d actual %0d",
                         name_i, exp_bad_i, got_bad);
                test_errs = test_errs + 1;
            end
            if (test_errs == 0) begin
                $display("%0s: ok, good +%0d, bad +%0d", name_i, got_ok, got_bad);
            end else begin
                $display("%0s: %0d mismatches", name_i, test_errs);
            end
            n_tests  = n_tests + 1;
            n_errors = n_errors + test_errs;
        end
    end

endmodule

/* verilog/tlk2711.sv */
`timescale 1ns/1ns

module tlk2711
    import tlk_pkg::*;
(
    input  logic             clk_80,
    input  logic             reset_i,
    input  logic             start_i,
    input  logic [1:0]       mode_i,
    output logic [15:0]      txd_o,
    output logic             tkmsb_o,
    output logic             tklsb_o,
    output logic             loopen_o,
    output logic             prbsen_o,
    output logic             enable_o,
    output logic             lckrefn_o,
    output logic             testen_o,
    output logic             tx_busy_o,
    input  logic [15:0]      rxd_i,
    input  logic             rkmsb_i,
    input  logic             rklsb_i,
    output logic [CNT_W-1:0] frames_ok_o,
    output logic [CNT_W-1:0] frames_bad_o
);

    logic     push;
    rx_word_t push_data;
    logic     pop;
    rx_word_t pop_data;
    logic     empty;

    tlk2711_tx tx_inst (
        .clk_80    (clk_80),
        .reset_i   (reset_i),
        .start_i   (start_i),
        .mode_i    (mode_i),
        .txd_o     (txd_o),
        .tkmsb_o   (tkmsb_o),
        .tklsb_o   (tklsb_o),
        .loopen_o  (loopen_o),
        .prbsen_o  (prbsen_o),
        .enable_o  (enable_o),
        .lckrefn_o (lckrefn_o),
        .testen_o  (testen_o),
        .tx_busy_o (tx_busy_o)
    );

    tlk2711_rx rx_inst (
        .clk_80      (clk_80),
        .reset_i     (reset_i),
        .rxd_i       (rxd_i),
        .rkmsb_i     (rkmsb_i),
        .rklsb_i     (rklsb_i),
        .push_o      (push),
        .push_data_o (push_data)
    );

    // decouples receiver from checker
    word_fifo #(
        .T (rx_word_t)
    ) fifo_inst (
        .clk_80      (clk_80),
        .reset_i     (reset_i),
        .push_i      (push),
        .push_data_i (push_data),
        .pop_i       (pop),
        .pop_data_o  (pop_data),
        .empty_o     (empty)
    );

    frame_checker checker_inst (
        .clk_80       (clk_80),
        .reset_i      (reset_i),
        .empty_i      (empty),
        .pop_data_i   (pop_data),
        .pop_o        (pop),
        .frames_ok_o  (frames_ok_o),
        .frames_bad_o (frames_bad_o)
    );

endmodule

/* verilog/frame_checker.sv */
`timescale 1ns/1ns

module frame_checker
    import tlk_pkg::*;
(
    input  logic             clk_80,
    input  logic             reset_i,
    input  logic             empty_i,
    input  rx_word_t         pop_data_i,
    output logic             pop_o,
    output logic [CNT_W-1:0] frames_ok_o,
    output logic [CNT_W-1:0] frames_bad_o
);

    logic [FRAME_IDX_W-1:0] pos;
    logic [15:0]            prev_data;
    logic                   seq_ok;
    logic                   seq_next;
    logic                   frame_good;

    // drain whenever something is there
    assign pop_o = !empty_i;

    // first word of a frame restarts the sequence
    always_comb begin
        if (pos == '0) begin
            seq_next = 1'b1;
        end else begin
            seq_next = seq_ok && (pop_data_i.data == prev_data + 16'd1);
        end
    end

    assign frame_good = seq_next && !pop_data_i.trunc &&
                        (pos == FRAME_IDX_W'(FRAME_LEN - 1));

    always_ff @(posedge clk_80) begin
        if (pop_o) begin
            prev_data <= pop_data_i.data;
        end
        if (reset_i) begin
            pos          <= '0;
            seq_ok       <= 1'b0;
            frames_ok_o  <= '0;
            frames_bad_o <= '0;
        end else if (pop_o) begin
            seq_ok <= seq_next;
            if (pop_data_i.last) begin
                pos <= '0;
                if (frame_good) begin
                    frames_ok_o <= frames_ok_o + 1'b1;
                end else begin
                    frames_bad_o <= frames_bad_o + 1'b1;
                end
            end else begin
                pos <= pos + 1'b1;
            end
        end
    end

endmodule

/* verilog/word_fifo.sv */
`timescale 1ns/1ns

module word_fifo
    import tlk_pkg::*;
#(
    parameter type T = logic [15:0]
) (
    input  logic clk_80,
    input  logic reset_i,
    input  logic push_i,
    input  T     push_data_i,
    input  logic pop_i,
    output T     pop_data_o,
    output logic empty_o
);

    T                      mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_PTR_W:0]   count;
    logic                  full;

    assign empty_o    = (count == '0);
    assign full       = (count == (FIFO_PTR_W + 1)'(FIFO_DEPTH));
    assign pop_data_o = mem[rd_ptr];

    always_ff @(posedge clk_80) begin
        if (push_i) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    // power-of-two depth lets the pointers wrap on their own
    always_ff @(posedge clk_80) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge clk_80) disable iff (reset_i)
        push_i |-> !full);

    a_no_underflow: assert property (@(posedge clk_80) disable iff (reset_i)
        pop_i |-> !empty_o);

endmodule

/* verilog/tlk2711_rx.sv */
`timescale 1ns/1ns

module tlk2711_rx
    import tlk_pkg::*;
(
    input  logic        clk_80,
    input  logic        reset_i,
    input  logic [15:0] rxd_i,
    input  logic        rkmsb_i,
    input  logic        rklsb_i,
    output logic        push_o,
    output rx_word_t    push_data_o
);

    logic [15:0]            rxd_q;
    logic                   rkmsb_q;
    logic                   rklsb_q;
    logic                   k_word;
    logic                   in_frame;
    logic [FRAME_IDX_W-1:0] pos;

    assign k_word = rkmsb_q | rklsb_q;

    // input register
    always_ff @(posedge clk_80) begin
        rxd_q <= rxd_i;
        if (reset_i) begin
            rkmsb_q <= 1'b0;
            rklsb_q <= 1'b0;
        end else begin
            rkmsb_q <= rkmsb_i;
            rklsb_q <= rklsb_i;
        end
    end

    always_ff @(posedge clk_80) begin
        push_data_o.data <= rxd_q;
        if (reset_i) begin
            in_frame <= 1'b0;
            pos      <= '0;
            push_o   <= 1'b0;
        end else begin
            push_o <= 1'b0;
            if (!in_frame) begin
                // commas and stray data dropped while hunting
                if (k_word && rxd_q == K_SOF) begin
                    in_frame <= 1'b1;
                    pos      <= '0;
                end
            end else if (k_word) begin
                push_o            <= 1'b1;
                push_data_o.last  <= 1'b1;
                push_data_o.trunc <= 1'b1;
                in_frame          <= 1'b0;
            end else begin
                push_o            <= 1'b1;
                push_data_o.trunc <= 1'b0;
                pos               <= pos + 1'b1;
                if (pos == FRAME_IDX_W'(FRAME_LEN - 1)) begin
                    push_data_o.last <= 1'b1;
                    in_frame         <= 1'b0;
                end else begin
                    push_data_o.last <= 1'b0;
                end
            end
        end
    end

    a_k_push_trunc: assert property (@(posedge clk_80) disable iff (reset_i)
        push_o && $past(k_word) |-> push_data_o.trunc);

endmodule

/* verilog/tlk2711_tx.sv */
`timescale 1ns/1ns

module tlk2711_tx
    import tlk_pkg::*;
(
    input  logic        clk_80,
    input  logic        reset_i,
    input  logic        start_i,
    input  logic [1:0]  mode_i,
    output logic [15:0] txd_o,
    output logic        tkmsb_o,
    output logic        tklsb_o,
    output logic        loopen_o,
    output logic        prbsen_o,
    output logic        enable_o,
    output logic        lckrefn_o,
    output logic        testen_o,
    output logic        tx_busy_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_SOF,
        S_DATA,
        S_GAP
    } state_t;

    // state names the word currently on txd_o
    state_t                 state;
    logic [FRAME_IDX_W-1:0] word_idx;
    logic [15:0]            payload_cnt;

    assign tx_busy_o = (state != S_IDLE);

    always_ff @(posedge clk_80) begin
        if (reset_i) begin
            state       <= S_IDLE;
            word_idx    <= '0;
            payload_cnt <= '0;
            txd_o       <= K_COMMA;
            tkmsb_o     <= 1'b1;
            tklsb_o     <= 1'b1;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start_i && mode_i == MODE_FRAME) begin
                        state <= S_SOF;
                        txd_o <= K_SOF;
                    end
                end
                S_SOF: begin
                    state       <= S_DATA;
                    word_idx    <= '0;
                    txd_o       <= payload_cnt;
                    payload_cnt <= payload_cnt + 16'd1;
                    tkmsb_o     <= 1'b0;
                    tklsb_o     <= 1'b0;
                end
                S_DATA: begin
                    if (word_idx == FRAME_IDX_W'(FRAME_LEN - 1)) begin
                        state    <= S_GAP;
                        word_idx <= '0;
                        txd_o    <= K_COMMA;
                        tkmsb_o  <= 1'b1;
                        tklsb_o  <= 1'b1;
                    end else begin
                        word_idx    <= word_idx + 1'b1;
                        txd_o       <= payload_cnt;
                        payload_cnt <= payload_cnt + 16'd1;
                    end
                end
                default: begin
                    // commas keep going out through the gap and idle
                    if (word_idx == FRAME_IDX_W'(IDLE_GAP - 1)) begin
                        state <= S_IDLE;
                    end else begin
                        word_idx <= word_idx + 1'b1;
                    end
                end
            endcase
        end
    end

    // static transceiver pins
    assign enable_o  = 1'b1;
    assign lckrefn_o = 1'b1;
    assign testen_o  = 1'b0;

    always_ff @(posedge clk_80) begin
        if (reset_i) begin
            loopen_o <= 1'b0;
            prbsen_o <= 1'b0;
        end else begin
            loopen_o <= (mode_i == MODE_LOOP);
            prbsen_o <= (mode_i == MODE_PRBS);
        end
    end

    a_data_not_k: assert property (@(posedge clk_80) disable iff (reset_i)
        state == S_DATA |-> !tkmsb_o && !tklsb_o);

endmodule

/* verilog/tlk_pkg.sv */
package tlk_pkg;

    // frame layout
    localparam int FRAME_LEN   = 16;
    localparam int FRAME_IDX_W = $clog2(FRAME_LEN);
    localparam int IDLE_GAP    = 2;

    // 8b/10b control words sent with both K flags set
    localparam logic [15:0] K_COMMA = 16'hBCBC;
    localparam logic [15:0] K_SOF   = 16'hFBFB;

    localparam logic [1:0] MODE_IDLE  = 2'd0;
    localparam logic [1:0] MODE_FRAME = 2'd1;
    localparam logic [1:0] MODE_PRBS  = 2'd2;
    localparam logic [1:0] MODE_LOOP  = 2'd3;

    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    localparam int CNT_W = 16;

    typedef struct packed {
        logic [15:0] data;
        logic        last;
        logic        trunc;
    } rx_word_t;

endpackage
